// File: common/axi_lite_if.sv
`timescale 1ns/10ps
`include "axil_rec_defs.svh"

interface axi_lite_if;

   logic [`AXIL_ADDR_W-1:0] awaddr;
   logic                    awvalid;
   logic                    awready;

   logic [`AXIL_DATA_W-1:0] wdata;
   logic [`AXIL_STRB_W-1:0] wstrb;
   logic                    wvalid;
   logic                    wready;

   logic [1:0]              bresp;
   logic                    bvalid;
   logic                    bready;

   logic [`AXIL_ADDR_W-1:0] araddr;
   logic                    arvalid;
   logic                    arready;

   logic [`AXIL_DATA_W-1:0] rdata;
   logic [1:0]              rresp;
   logic                    rvalid;
   logic                    rready;

   modport master (
      output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
      input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

   modport slave (
      input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
      output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
   );

endinterface

// File: common/axil_rec_defs.svh
`ifndef AXIL_REC_DEFS_SVH
`define AXIL_REC_DEFS_SVH

// AXI-Lite field widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4

// Entries in each per-channel side FIFO
`define REC_CHAN_DEPTH 4

// Entries in the record packet FIFO
`define REC_PKT_DEPTH 8

// Width of one log word on the drain output
`define REC_LOG_W 32

`endif

// File: common/axil_rec_pkg.sv
`include "axil_rec_defs.svh"

package axil_rec_pkg;

   // Slot positions inside a record packet
   typedef enum logic [1:0] {
      AW = 2'd0,
      W  = 2'd1,
      AR = 2'd2
   } rec_chan_e;

   // Bit 0 is AW, bit 1 is W, bit 2 is AR
   typedef struct packed {
      logic ar_valid;
      logic w_valid;
      logic aw_valid;
   } rec_hdr_t;

   // Absent channels carry a zero payload
   typedef struct packed {
      rec_hdr_t                 hdr;
      logic [`AXIL_ADDR_W-1:0]  aw_addr;
      logic [`AXIL_DATA_W-1:0]  w_data;
      logic [`AXIL_STRB_W-1:0]  w_strb;
      logic [`AXIL_ADDR_W-1:0]  ar_addr;
   } rec_packet_t;

   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      HDR     = 3'd1,
      AW_ADDR = 3'd2,
      W_DATA  = 3'd3,
      W_STRB  = 3'd4,
      AR_ADDR = 3'd5
   } drain_state_e;

endpackage

// File: common/rec_stream_if.sv
`timescale 1ns/10ps

interface rec_stream_if import axil_rec_pkg::*; ();

   logic        valid;
   logic        ready;
   rec_packet_t packet;

   modport producer (
      output valid, packet,
      input  ready
   );

   modport consumer (
      input  valid, packet,
      output ready
   );

endinterface

// File: filelist.f
+incdir+common
common/axil_rec_pkg.sv
common/axi_lite_if.sv
common/rec_stream_if.sv
recorder/channel_siderec.sv
recorder/axil_mstr_recorder.sv
verilog/rec_packet_fifo.sv
verilog/rec_log_drain.sv
verilog/axil_rec_top.sv
testbench/axil_rec_tb.sv

// File: recorder/axil_mstr_recorder.sv
`timescale 1ns/10ps
`include "axil_rec_defs.svh"

module axil_mstr_recorder import axil_rec_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   axi_lite_if.slave     ups,
   axi_lite_if.master    dns,
   rec_stream_if.producer rec
);

   logic [`AXIL_ADDR_W-1:0]                aw_head;
   logic [`AXIL_DATA_W+`AXIL_STRB_W-1:0]  w_head;
   logic [`AXIL_ADDR_W-1:0]                ar_head;
   logic                                   aw_ne;
   logic                                   w_ne;
   logic                                   ar_ne;
   logic                                   rec_fire;
   rec_packet_t                            pkt;

   // B and R are not recorded
   assign ups.bresp  = dns.bresp;
   assign ups.bvalid = dns.bvalid;
   assign dns.bready = ups.bready;
   assign ups.rdata  = dns.rdata;
   assign ups.rresp  = dns.rresp;
   assign ups.rvalid = dns.rvalid;
   assign dns.rready = ups.rready;

   assign dns.awaddr = ups.awaddr;
   assign dns.wdata  = ups.wdata;
   assign dns.wstrb  = ups.wstrb;
   assign dns.araddr = ups.araddr;

   assign rec_fire = rec.valid & rec.ready;

   channel_siderec #(.DEPTH(`REC_CHAN_DEPTH), .WIDTH(`AXIL_ADDR_W)) aw_rec (
      .clk        (clk),
      .reset      (reset),
      .din        (ups.awaddr),
      .up_valid   (ups.awvalid),
      .down_ready (dns.awready),
      .up_ready   (ups.awready),
      .down_valid (dns.awvalid),
      .pop        (rec_fire & aw_ne),
      .head       (aw_head),
      .not_empty  (aw_ne)
   );

   channel_siderec #(.DEPTH(`REC_CHAN_DEPTH), .WIDTH(`AXIL_DATA_W + `AXIL_STRB_W)) w_rec (
      .clk        (clk),
      .reset      (reset),
      .din        ({ups.wdata, ups.wstrb}),
      .up_valid   (ups.wvalid),
      .down_ready (dns.wready),
      .up_ready   (ups.wready),
      .down_valid (dns.wvalid),
      .pop        (rec_fire & w_ne),
      .head       (w_head),
      .not_empty  (w_ne)
   );

   channel_siderec #(.DEPTH(`REC_CHAN_DEPTH), .WIDTH(`AXIL_ADDR_W)) ar_rec (
      .clk        (clk),
      .reset      (reset),
      .din        (ups.araddr),
      .up_valid   (ups.arvalid),
      .down_ready (dns.arready),
      .up_ready   (ups.arready),
      .down_valid (dns.arvalid),
      .pop        (rec_fire & ar_ne),
      .head       (ar_head),
      .not_empty  (ar_ne)
   );

   // Empty channels leave a zero bubble in their slot
   always_comb begin
      pkt.hdr.aw_valid = aw_ne;
      pkt.hdr.w_valid  = w_ne;
      pkt.hdr.ar_valid = ar_ne;
      pkt.aw_addr      = aw_ne ? aw_head : '0;
      {pkt.w_data, pkt.w_strb} = w_ne ? w_head : '0;
      pkt.ar_addr      = ar_ne ? ar_head : '0;
   end

   assign rec.packet = pkt;
   assign rec.valid  = aw_ne | w_ne | ar_ne;

   a_hdr_nonzero: assert property (@(posedge clk) disable iff (reset)
      rec.valid |-> rec.packet.hdr != '0)
      else $error("record packet without any channel");

endmodule

// File: recorder/channel_siderec.sv
`timescale 1ns/10ps

module channel_siderec #(
   parameter int DEPTH = 4,
   parameter int WIDTH = 32
) (
   input  logic             clk,
   input  logic             reset,
   input  logic [WIDTH-1:0] din,
   input  logic             up_valid,
   input  logic             down_ready,
   output logic             up_ready,
   output logic             down_valid,
   input  logic             pop,
   output logic [WIDTH-1:0] head,
   output logic             not_empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             push;

   assign full      = (count == CNT_W'(DEPTH));
   assign not_empty = (count != '0);

   // Both sides only see the handshake while there is room to copy it
   assign up_ready   = down_ready & ~full;
   assign down_valid = up_valid & ~full;
   assign push       = up_valid & down_ready & ~full;

   assign head = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Pop comes from the packet assembly in the parent
   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
      pop |-> not_empty)
      else $error("side FIFO popped while empty");

   // A full buffer cannot take a new entry until one leaves
   a_no_push_full: assert property (@(posedge clk) disable iff (reset)
      full && !pop |=> full && (count == $past(count)))
      else $error("side FIFO written while full");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f filelist.f --top-module axil_rec_tb

# The result is the status of grep, which looks for the pass line
./obj_dir/Vaxil_rec_tb | tee /dev/stderr | grep -x "test passed" > /dev/null

// File: testbench/axil_rec_tb.sv
`timescale 1ns/10ps
`include "axil_rec_defs.svh"

module axil_rec_tb;

   logic                    clk = 1'b0;
   logic                    reset;
   logic [`AXIL_ADDR_W-1:0] s_axil_awaddr;
   logic                    s_axil_awvalid;
   logic                    s_axil_awready;
   logic [`AXIL_DATA_W-1:0] s_axil_wdata;
   logic [`AXIL_STRB_W-1:0] s_axil_wstrb;
   logic                    s_axil_wvalid;
   logic                    s_axil_wready;
   logic [1:0]              s_axil_bresp;
   logic                    s_axil_bvalid;
   logic                    s_axil_bready;
   logic [`AXIL_ADDR_W-1:0] s_axil_araddr;
   logic                    s_axil_arvalid;
   logic                    s_axil_arready;
   logic [`AXIL_DATA_W-1:0] s_axil_rdata;
   logic [1:0]              s_axil_rresp;
   logic                    s_axil_rvalid;
   logic                    s_axil_rready;
   logic [`AXIL_ADDR_W-1:0] m_axil_awaddr;
   logic                    m_axil_awvalid;
   logic                    m_axil_awready = 1'b0;
   logic [`AXIL_DATA_W-1:0] m_axil_wdata;
   logic [`AXIL_STRB_W-1:0] m_axil_wstrb;
   logic                    m_axil_wvalid;
   logic                    m_axil_wready = 1'b0;
   logic [1:0]              m_axil_bresp = 2'b00;
   logic                    m_axil_bvalid = 1'b0;
   logic                    m_axil_bready;
   logic [`AXIL_ADDR_W-1:0] m_axil_araddr;
   logic                    m_axil_arvalid;
   logic                    m_axil_arready = 1'b0;
   logic [`AXIL_DATA_W-1:0] m_axil_rdata = '0;
   logic [1:0]              m_axil_rresp = 2'b00;
   logic                    m_axil_rvalid = 1'b0;
   logic                    m_axil_rready;
   logic [`REC_LOG_W-1:0]   log_data;
   logic                    log_valid;
   logic                    log_ready = 1'b0;

   // Trace columns with one entry per line
   int          tr_test [$];
   logic [7:0]  tr_op [$];
   logic [31:0] tr_addr [$];
   logic [31:0] tr_data [$];
   logic [3:0]  tr_strb [$];
   int          tr_mode [$];

   logic [31:0] exp_q [$];
   logic [31:0] mem_model [logic [31:0]];
   logic [31:0] exp_mem [logic [31:0]];

   integer      seed = 14544;
   logic [31:0] rnd_word = '0;
   int          cycle_cnt = 0;
   int          cycle_limit = 0;
   int          log_idx = 0;
   int          log_err = 0;
   int          err_main = 0;
   int          gate_cnt = 0;
   int          cur_mode = 0;
   int          stall_id = 0;
   int          seen_stall = 0;
   int          hold_left = 0;

   axil_rec_top dut (.*);

   always #10 clk = ~clk;

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                               input logic [31:0] data,
                                               input logic [3:0]  strb);
      logic [31:0] res;
      res = old_val;
      for (int i = 0; i < 4; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = data[8*i +: 8];
         end
      end
      return res;
   endfunction

   always @(posedge clk) begin
      rnd_word <= $random(seed);
   end

   // Downstream slave model with random ready
   // AW and W ready come from one draw
   always @(posedge clk) begin
      if (reset) begin
         m_axil_awready <= 1'b0;
         m_axil_wready  <= 1'b0;
         m_axil_arready <= 1'b0;
         m_axil_bvalid  <= 1'b0;
         m_axil_rvalid  <= 1'b0;
      end else begin
         m_axil_awready <= (rnd_word[2:0] != 3'd0);
         m_axil_wready  <= (rnd_word[2:0] != 3'd0);
         m_axil_arready <= (rnd_word[5:3] != 3'd0);
         if (m_axil_awvalid && m_axil_awready && m_axil_wvalid && m_axil_wready) begin
            mem_model[m_axil_awaddr] = merge_bytes(
               mem_model.exists(m_axil_awaddr) ? mem_model[m_axil_awaddr] : 32'd0,
               m_axil_wdata, m_axil_wstrb);
            m_axil_bresp  <= 2'b00;
            m_axil_bvalid <= 1'b1;
         end else if (m_axil_bvalid && m_axil_bready) begin
            m_axil_bvalid <= 1'b0;
         end
         if (m_axil_arvalid && m_axil_arready) begin
            m_axil_rdata  <= mem_model.exists(m_axil_araddr) ? mem_model[m_axil_araddr] : 32'd0;
            m_axil_rresp  <= 2'b00;
            m_axil_rvalid <= 1'b1;
         end else if (m_axil_rvalid && m_axil_rready) begin
            m_axil_rvalid <= 1'b0;
         end
      end
   end

   // A new stall request holds log_ready low for 40 cycles
   always @(posedge clk) begin
      if (reset) begin
         log_ready  <= 1'b0;
         hold_left  <= 0;
         seen_stall <= stall_id;
      end else if (stall_id != seen_stall) begin
         seen_stall <= stall_id;
         hold_left  <= 39;
         log_ready  <= 1'b0;
      end else if (hold_left != 0) begin
         hold_left <= hold_left - 1;
         log_ready <= 1'b0;
      end else if (cur_mode == 1) begin
         log_ready <= rnd_word[7];
      end else begin
         log_ready <= 1'b1;
      end
   end

   always @(posedge clk) begin
      if (!reset && log_valid && log_ready) begin
         assert (log_idx < exp_q.size()) else begin
            $display("log word %h arrived with no transaction left to match it", log_data);
            log_err <= log_err + 1;
         end
         if (log_idx < exp_q.size()) begin
            assert (log_data == exp_q[log_idx]) else begin
               $display("** Error log_data expected %h got %h", exp_q[log_idx], log_data);
               log_err <= log_err + 1;
            end
         end
         log_idx <= log_idx + 1;
      end
   end

   // Upstream awready held off by a full side FIFO
   always @(posedge clk) begin
      if (!reset && s_axil_awvalid && m_axil_awready && !s_axil_awready) begin
         gate_cnt <= gate_cnt + 1;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         $display("timeout, the run exceeded %0d cycles", cycle_limit);
         $display("test failed");
         $finish;
      end
   end

   task automatic load_trace();
      int          fd;
      int          got;
      string       line;
      int          tnum;
      logic [7:0]  op_c;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  strb;
      int          mode;
      fd = $fopen("testbench/axil_rec_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open the trace file");
         err_main++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.getc(0) != "#") begin
               got = $sscanf(line, "%d %s %h %h %h %d", tnum, op_c, addr, data, strb, mode);
               if (got == 6) begin
                  tr_test.push_back(tnum);
                  tr_op.push_back(op_c);
                  tr_addr.push_back(addr);
                  tr_data.push_back(data);
                  tr_strb.push_back(strb);
                  tr_mode.push_back(mode);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic [31:0] new_val;
      logic [31:0] got;
      new_val = merge_bytes(exp_mem.exists(addr) ? exp_mem[addr] : 32'd0, data, strb);
      exp_mem[addr] = new_val;
      s_axil_awaddr  <= addr;
      s_axil_awvalid <= 1'b1;
      s_axil_wdata   <= data;
      s_axil_wstrb   <= strb;
      s_axil_wvalid  <= 1'b1;
      do @(posedge clk); while (!s_axil_awready && !s_axil_wready);
      assert (s_axil_awready && s_axil_wready) else begin
         $display("AW and W of the write to %h were accepted in different cycles", addr);
         err_main++;
      end
      s_axil_awvalid <= 1'b0;
      s_axil_wvalid  <= 1'b0;
      do @(posedge clk); while (!s_axil_bvalid);
      assert (s_axil_bresp == 2'b00) else begin
         $display("** Error s_axil_bresp expected %h got %h", 2'b00, s_axil_bresp);
         err_main++;
      end
      got = mem_model.exists(addr) ? mem_model[addr] : 32'd0;
      assert (got == new_val) else begin
         $display("** Error mem_model expected %h got %h", new_val, got);
         err_main++;
      end
   endtask

   task automatic read_txn(input logic [31:0] addr);
      logic [31:0] expected;
      expected = exp_mem.exists(addr) ? exp_mem[addr] : 32'd0;
      s_axil_araddr  <= addr;
      s_axil_arvalid <= 1'b1;
      do @(posedge clk); while (!s_axil_arready);
      s_axil_arvalid <= 1'b0;
      do @(posedge clk); while (!s_axil_rvalid);
      assert (s_axil_rdata == expected) else begin
         $display("** Error s_axil_rdata expected %h got %h", expected, s_axil_rdata);
         err_main++;
      end
      assert (s_axil_rresp == 2'b00) else begin
         $display("** Error s_axil_rresp expected %h got %h", 2'b00, s_axil_rresp);
         err_main++;
      end
   endtask

   initial begin : main_seq
      int idx;
      int tnum;
      int mode;
      int n_trans;
      int n_tests;
      int word_start;
      int err_start;
      int gate_start;
      reset          = 1'b1;
      s_axil_awaddr  = '0;
      s_axil_awvalid = 1'b0;
      s_axil_wdata   = '0;
      s_axil_wstrb   = '0;
      s_axil_wvalid  = 1'b0;
      s_axil_bready  = 1'b0;
      s_axil_araddr  = '0;
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b0;
      n_tests = 0;
      load_trace();
      cycle_limit = 200 * tr_test.size() + 500;
      repeat (16) @(posedge clk);
      reset         <= 1'b0;
      s_axil_bready <= 1'b1;
      s_axil_rready <= 1'b1;
      @(posedge clk);
      idx = 0;
      while (idx < tr_test.size()) begin
         tnum       = tr_test[idx];
         mode       = tr_mode[idx];
         n_trans    = 0;
         word_start = exp_q.size();
         err_start  = err_main + log_err;
         gate_start = gate_cnt;
         cur_mode <= mode;
         if (mode == 2) begin
            stall_id <= stall_id + 1;
         end
         while (idx < tr_test.size() && tr_test[idx] == tnum) begin
            if (tr_op[idx] == "W") begin
               exp_q.push_back(32'd3);
               exp_q.push_back(tr_addr[idx]);
               exp_q.push_back(tr_data[idx]);
               exp_q.push_back({28'd0, tr_strb[idx]});
               write_txn(tr_addr[idx], tr_data[idx], tr_strb[idx]);
            end else begin
               exp_q.push_back(32'd4);
               exp_q.push_back(tr_addr[idx]);
               read_txn(tr_addr[idx]);
            end
            n_trans++;
            idx++;
         end
         while (log_idx != exp_q.size()) begin
            @(posedge clk);
         end
         if (mode == 2) begin
            assert (gate_cnt != gate_start) else begin
               $display("upstream awready never dropped while the log was stalled");
               err_main++;
            end
         end
         n_tests++;
         $display("test %0d: %0d transactions, %0d log words, %0d errors", tnum, n_trans,
                  exp_q.size() - word_start, err_main + log_err - err_start);
      end
      // Stray words after the last transaction
      repeat (20) @(posedge clk);
      assert (log_idx == exp_q.size()) else begin
         $display("log produced %0d words where %0d were expected", log_idx, exp_q.size());
         err_main++;
      end
      $display("%0d tests, %0d transactions, %0d log words, %0d errors", n_tests,
               tr_test.size(), log_idx, err_main + log_err);
      if (err_main + log_err == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: testbench/axil_rec_trace.txt
# test op addr data strb log_ready_mode
# op W writes data under strb, R reads; mode 0 ready, 1 random, 2 held low 40 cycles
1 W 00000010 11223344 f 0
1 W 00000014 a5a5a5a5 f 0
1 W 00000010 deadbeef 3 0
1 R 00000010 00000000 0 0
1 R 00000020 00000000 0 0
1 R 00000014 00000000 0 0
2 W 00000100 cafef00d c 1
2 W 00000104 0badc0de 5 1
2 R 00000100 00000000 0 1
2 R 00000104 00000000 0 1
2 R 00000010 00000000 0 1
3 W 00000200 10000001 f 2
3 W 00000204 20000002 f 2
3 W 00000208 30000003 1 2
3 W 0000020c 40000004 f 2
3 W 00000210 50000005 2 2
3 W 00000214 60000006 f 2
3 W 00000218 70000007 f 2
3 W 0000021c 80000008 4 2
3 W 00000220 90000009 f 2
3 W 00000224 a000000a f 2
3 W 00000228 b000000b 8 2
3 W 0000022c c000000c f 2
3 W 00000230 d000000d f 2
3 W 00000234 e000000e 6 2
3 W 00000238 f000000f f 2

// File: verilog/axil_rec_top.sv
`timescale 1ns/10ps
`include "axil_rec_defs.svh"

module axil_rec_top (
   input  logic                    clk,
   input  logic                    reset,
   // Upstream side, from the AXI-Lite master
   input  logic [`AXIL_ADDR_W-1:0] s_axil_awaddr,
   input  logic                    s_axil_awvalid,
   output logic                    s_axil_awready,
   input  logic [`AXIL_DATA_W-1:0] s_axil_wdata,
   input  logic [`AXIL_STRB_W-1:0] s_axil_wstrb,
   input  logic                    s_axil_wvalid,
   output logic                    s_axil_wready,
   output logic [1:0]              s_axil_bresp,
   output logic                    s_axil_bvalid,
   input  logic                    s_axil_bready,
   input  logic [`AXIL_ADDR_W-1:0] s_axil_araddr,
   input  logic                    s_axil_arvalid,
   output logic                    s_axil_arready,
   output logic [`AXIL_DATA_W-1:0] s_axil_rdata,
   output logic [1:0]              s_axil_rresp,
   output logic                    s_axil_rvalid,
   input  logic                    s_axil_rready,
   // Downstream side, to the AXI-Lite slave
   output logic [`AXIL_ADDR_W-1:0] m_axil_awaddr,
   output logic                    m_axil_awvalid,
   input  logic                    m_axil_awready,
   output logic [`AXIL_DATA_W-1:0] m_axil_wdata,
   output logic [`AXIL_STRB_W-1:0] m_axil_wstrb,
   output logic                    m_axil_wvalid,
   input  logic                    m_axil_wready,
   input  logic [1:0]              m_axil_bresp,
   input  logic                    m_axil_bvalid,
   output logic                    m_axil_bready,
   output logic [`AXIL_ADDR_W-1:0] m_axil_araddr,
   output logic                    m_axil_arvalid,
   input  logic                    m_axil_arready,
   input  logic [`AXIL_DATA_W-1:0] m_axil_rdata,
   input  logic [1:0]              m_axil_rresp,
   input  logic                    m_axil_rvalid,
   output logic                    m_axil_rready,
   // Log word stream
   output logic [`REC_LOG_W-1:0]   log_data,
   output logic                    log_valid,
   input  logic                    log_ready
);

   axi_lite_if   ups_bus ();
   axi_lite_if   dns_bus ();
   rec_stream_if rec_bus ();
   rec_stream_if log_bus ();

   assign ups_bus.awaddr  = s_axil_awaddr;
   assign ups_bus.awvalid = s_axil_awvalid;
   assign s_axil_awready  = ups_bus.awready;
   assign ups_bus.wdata   = s_axil_wdata;
   assign ups_bus.wstrb   = s_axil_wstrb;
   assign ups_bus.wvalid  = s_axil_wvalid;
   assign s_axil_wready   = ups_bus.wready;
   assign s_axil_bresp    = ups_bus.bresp;
   assign s_axil_bvalid   = ups_bus.bvalid;
   assign ups_bus.bready  = s_axil_bready;
   assign ups_bus.araddr  = s_axil_araddr;
   assign ups_bus.arvalid = s_axil_arvalid;
   assign s_axil_arready  = ups_bus.arready;
   assign s_axil_rdata    = ups_bus.rdata;
   assign s_axil_rresp    = ups_bus.rresp;
   assign s_axil_rvalid   = ups_bus.rvalid;
   assign ups_bus.rready  = s_axil_rready;

   assign m_axil_awaddr   = dns_bus.awaddr;
   assign m_axil_awvalid  = dns_bus.awvalid;
   assign dns_bus.awready = m_axil_awready;
   assign m_axil_wdata    = dns_bus.wdata;
   assign m_axil_wstrb    = dns_bus.wstrb;
   assign m_axil_wvalid   = dns_bus.wvalid;
   assign dns_bus.wready  = m_axil_wready;
   assign dns_bus.bresp   = m_axil_bresp;
   assign dns_bus.bvalid  = m_axil_bvalid;
   assign m_axil_bready   = dns_bus.bready;
   assign m_axil_araddr   = dns_bus.araddr;
   assign m_axil_arvalid  = dns_bus.arvalid;
   assign dns_bus.arready = m_axil_arready;
   assign dns_bus.rdata   = m_axil_rdata;
   assign dns_bus.rresp   = m_axil_rresp;
   assign dns_bus.rvalid  = m_axil_rvalid;
   assign m_axil_rready   = dns_bus.rready;

   axil_mstr_recorder recorder (
      .clk   (clk),
      .reset (reset),
      .ups   (ups_bus.slave),
      .dns   (dns_bus.master),
      .rec   (rec_bus.producer)
   );

   rec_packet_fifo #(.DEPTH(`REC_PKT_DEPTH)) pkt_fifo (
      .clk   (clk),
      .reset (reset),
      .wr    (rec_bus.consumer),
      .rd    (log_bus.producer)
   );

   rec_log_drain drain (
      .clk       (clk),
      .reset     (reset),
      .pkt       (log_bus.consumer),
      .log_data  (log_data),
      .log_valid (log_valid),
      .log_ready (log_ready)
   );

endmodule

// File: verilog/rec_log_drain.sv
`timescale 1ns/10ps
`include "axil_rec_defs.svh"

module rec_log_drain import axil_rec_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   rec_stream_if.consumer        pkt,
   output logic [`REC_LOG_W-1:0] log_data,
   output logic                  log_valid,
   input  logic                  log_ready
);

   drain_state_e state;
   rec_packet_t  cur;
   logic         word_fire;

   // First word at or after the given slot whose header bit is set
   function automatic drain_state_e next_word(rec_chan_e from, rec_hdr_t hdr);
      drain_state_e nxt;
      nxt = IDLE;
      if (from == AW && hdr.aw_valid) begin
         nxt = AW_ADDR;
      end else if (from != AR && hdr.w_valid) begin
         nxt = W_DATA;
      end else if (hdr.ar_valid) begin
         nxt = AR_ADDR;
      end
      return nxt;
   endfunction

   assign pkt.ready = (state == IDLE);
   assign log_valid = (state != IDLE);
   assign word_fire = log_valid & log_ready;

   always_comb begin
      case (state)
         HDR:     log_data = {{(`REC_LOG_W - $bits(rec_hdr_t)){1'b0}}, cur.hdr};
         AW_ADDR: log_data = cur.aw_addr;
         W_DATA:  log_data = cur.w_data;
         W_STRB:  log_data = {{(`REC_LOG_W - `AXIL_STRB_W){1'b0}}, cur.w_strb};
         AR_ADDR: log_data = cur.ar_addr;
         default: log_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (pkt.valid && pkt.ready) begin
         cur <= pkt.packet;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:    if (pkt.valid) state <= HDR;
            HDR:     if (word_fire) state <= next_word(AW, cur.hdr);
            AW_ADDR: if (word_fire) state <= next_word(W, cur.hdr);
            W_DATA:  if (word_fire) state <= W_STRB;
            W_STRB:  if (word_fire) state <= next_word(AR, cur.hdr);
            AR_ADDR: if (word_fire) state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // Held word must not change under back-pressure
   a_log_stable: assert property (@(posedge clk) disable iff (reset)
      log_valid && !log_ready |=> log_valid && $stable(log_data))
      else $error("log word changed while stalled");

endmodule

// File: verilog/rec_packet_fifo.sv
`timescale 1ns/10ps

module rec_packet_fifo import axil_rec_pkg::*; #(
   parameter int DEPTH = 8
) (
   input  logic           clk,
   input  logic           reset,
   rec_stream_if.consumer wr,
   rec_stream_if.producer rd
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   rec_packet_t      mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_nxt;
   logic             full;
   logic             empty;
   logic             push;
   logic             pull;

   assign wr.ready  = ~full;
   assign rd.valid  = ~empty;
   assign rd.packet = mem[rd_ptr];

   assign push = wr.valid & ~full;
   assign pull = rd.ready & ~empty;

   always_comb begin
      count_nxt = count;
      if (push && !pull) begin
         count_nxt = count + 1'b1;
      end else if (pull && !push) begin
         count_nxt = count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr.packet;
      end
   end

   // Flags come from the next count so they are plain registers
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         full   <= 1'b0;
         empty  <= 1'b1;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pull) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count_nxt;
         full  <= (count_nxt == CNT_W'(DEPTH));
         empty <= (count_nxt == '0);
      end
   end

   a_count_bound: assert property (@(posedge clk) disable iff (reset)
      count <= CNT_W'(DEPTH))
      else $error("packet FIFO count above depth");

endmodule
